// ==== src/pulse_filter_pkg.sv ====
package pulse_filter_pkg;

	// ----------------------------------------------------------------------
	// widths and constants
	// ----------------------------------------------------------------------

	// one sensor pixel
	localparam int PIX_W           = 8;
	// margin over th before a pixel counts as a bright pulse
	localparam int PULSE_THRESHOLD = 25;
	// window of 9 pixels, same-colour taps at -4 -2 0 +2 +4
	localparam int WIN_LEN         = 9;
	// pixels at each line end that pass unchanged
	localparam int EDGE_PIX        = 4;
	// input to output, in clocks
	localparam int PIPE_LAT        = 8;
	// control chain depth, one less for the output register
	localparam int CTRL_DLY        = PIPE_LAT - 1;
	// register widths
	localparam int WIDTH_W         = 16;
	localparam int COUNT_W         = 16;

	// ----------------------------------------------------------------------
	// vector types
	// ----------------------------------------------------------------------

	typedef logic [PIX_W-1:0]   pix_t;
	// m, n, th need one bit over a pixel
	typedef logic [PIX_W:0]     bound_t;
	typedef logic [WIDTH_W-1:0] width_t;
	typedef logic [COUNT_W-1:0] count_t;

	// ----------------------------------------------------------------------
	// bundles between the blocks
	// ----------------------------------------------------------------------

	// timing and position, 4 bits
	typedef struct packed {
		logic fval;
		logic lval;
		logic edge_pix;
		logic filt_en;
	} video_ctrl_t;

	// detector result, 17 bits
	typedef struct packed {
		pix_t pix_orig;
		pix_t pix_fix;
		logic pulse;
	} det_result_t;

endpackage

// ==== src/impulse_detect.sv ====
module impulse_detect (
	input  logic                          clk,
	input  logic                          i_rst_n,
	input  pulse_filter_pkg::pix_t        i_pix,
	output pulse_filter_pkg::det_result_t o_det
);
	import pulse_filter_pkg::*;

	// pixel window, index 0 is the newest sample
	pix_t win [WIN_LEN];

	// same-colour taps, p2 is the centre
	pix_t p0;
	pix_t p1;
	pix_t p2;
	pix_t p3;
	pix_t p4;

	// stage 1 registers
	bound_t m_q;
	bound_t n_q;
	pix_t   ctr_q;

	// stage 2 inputs
	bound_t           th_w;
	logic [PIX_W+1:0] lim_w;

	// stage 2 register
	det_result_t det_q;

	// near + |near - far|
	function automatic bound_t side_bound(input pix_t near, input pix_t far);
		bound_t b;
		if (near >= far) begin
			b = bound_t'(near) + bound_t'(near - far);
		end else begin
			b = bound_t'(near) + bound_t'(far - near);
		end
		return b;
	endfunction

	// ----------------------------------------------------------------------
	// window shift, runs every clock
	// ----------------------------------------------------------------------

	// no line awareness here, edges are handled downstream
	always_ff @(posedge clk) begin
		win[0] <= i_pix;
		for (int i = 1; i < WIN_LEN; i++) begin
			win[i] <= win[i-1];
		end
	end

	// bayer pattern, same colour every second column
	assign p4 = win[0];
	assign p3 = win[2];
	assign p2 = win[(WIN_LEN-1)/2];
	assign p1 = win[WIN_LEN-3];
	assign p0 = win[WIN_LEN-1];

	// ----------------------------------------------------------------------
	// stage 1: m and n
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			m_q   <= '0;
			n_q   <= '0;
			ctr_q <= '0;
		end else begin
			// m from the left pair, n from the right pair
			m_q   <= side_bound(p1, p0);
			n_q   <= side_bound(p3, p4);
			ctr_q <= p2;
		end
	end

	// ----------------------------------------------------------------------
	// stage 2: th and compare
	// ----------------------------------------------------------------------

	assign th_w  = (m_q >= n_q) ? m_q : n_q;
	// th plus margin, two spare bits so nothing wraps
	assign lim_w = {1'b0, th_w} + (PIX_W+2)'(PULSE_THRESHOLD);

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			det_q <= '0;
		end else begin
			det_q.pix_orig <= ctr_q;
			// only used when pulse is set, th is then below 255
			det_q.pix_fix  <= th_w[PIX_W-1:0];
			// bright pulses only
			det_q.pulse    <= {2'b00, ctr_q} > lim_w;
		end
	end

	assign o_det = det_q;

endmodule

// ==== src/line_position.sv ====
module line_position (
	input  logic                          clk,
	input  logic                          i_rst_n,
	input  logic                          i_fval,
	input  logic                          i_lval,
	input  logic                          i_filter_en,
	input  pulse_filter_pkg::width_t      i_line_width,
	output pulse_filter_pkg::video_ctrl_t o_ctrl
);
	import pulse_filter_pkg::*;

	// column of the pixel now at the input
	width_t col_cnt;
	// enable held for the whole frame
	logic frame_en;
	// control of the input pixel, before the delay
	video_ctrl_t ctrl_in;
	// delay chain, last stage lines up with the detector
	video_ctrl_t ctrl_dly [CTRL_DLY];

	// ----------------------------------------------------------------------
	// column counter
	// ----------------------------------------------------------------------

	// counts accepted pixels, back to 0 between lines
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col_cnt <= '0;
		end else if (i_fval && i_lval) begin
			col_cnt <= col_cnt + width_t'(1);
		end else begin
			col_cnt <= '0;
		end
	end

	// ----------------------------------------------------------------------
	// per-frame enable
	// ----------------------------------------------------------------------

	// sampled only between frames
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			frame_en <= 1'b0;
		end else if (!i_fval) begin
			frame_en <= i_filter_en;
		end
	end

	// ----------------------------------------------------------------------
	// control word at the input
	// ----------------------------------------------------------------------

	always_comb begin
		ctrl_in.fval     = i_fval;
		ctrl_in.lval     = i_lval;
		// first and last EDGE_PIX columns lack a full window
		ctrl_in.edge_pix = (col_cnt < width_t'(EDGE_PIX)) ||
		                   (col_cnt >= i_line_width - width_t'(EDGE_PIX));
		ctrl_in.filt_en  = frame_en;
	end

	// ----------------------------------------------------------------------
	// delay chain
	// ----------------------------------------------------------------------

	// matches the window and the two compute stages
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < CTRL_DLY; i++) begin
				ctrl_dly[i] <= '0;
			end
		end else begin
			ctrl_dly[0] <= ctrl_in;
			for (int i = 1; i < CTRL_DLY; i++) begin
				ctrl_dly[i] <= ctrl_dly[i-1];
			end
		end
	end

	assign o_ctrl = ctrl_dly[CTRL_DLY-1];

endmodule

// ==== src/pixel_select.sv ====
module pixel_select (
	input  logic                          clk,
	input  logic                          i_rst_n,
	input  pulse_filter_pkg::det_result_t i_det,
	input  pulse_filter_pkg::video_ctrl_t i_ctrl,
	output logic                          o_fval,
	output logic                          o_lval,
	output pulse_filter_pkg::pix_t        o_pix,
	output pulse_filter_pkg::count_t      o_pulse_num
);
	import pulse_filter_pkg::*;

	// output register
	logic fval_q;
	logic lval_q;
	logic en_q;
	pix_t pix_q;

	// frame edges of the delayed fval
	logic fval_rise;
	logic fval_fall;

	// this pixel gets replaced by th
	logic replace;

	// running count and the published value
	count_t pulse_cnt;
	count_t pulse_num_q;

	// ----------------------------------------------------------------------
	// replacement decision
	// ----------------------------------------------------------------------

	// edge pixels always pass, disabled frames too
	assign replace = i_ctrl.filt_en & i_ctrl.lval & i_det.pulse & ~i_ctrl.edge_pix;

	// fval_q is the delayed fval one clock later
	assign fval_rise = i_ctrl.fval & ~fval_q;
	assign fval_fall = ~i_ctrl.fval & fval_q;

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			fval_q <= 1'b0;
			lval_q <= 1'b0;
			en_q   <= 1'b0;
		end else begin
			fval_q <= i_ctrl.fval;
			lval_q <= i_ctrl.lval;
			// kept for the frame end, chain may carry the next enable by then
			en_q   <= i_ctrl.filt_en;
		end
	end

	// pixel only loads inside lines, holds between them
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pix_q <= '0;
		end else if (i_ctrl.lval) begin
			pix_q <= replace ? i_det.pix_fix : i_det.pix_orig;
		end
	end

	// ----------------------------------------------------------------------
	// pulse count per frame
	// ----------------------------------------------------------------------

	// restart at frame start, first pixel included
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pulse_cnt <= '0;
		end else if (fval_rise) begin
			pulse_cnt <= count_t'(replace);
		end else if (replace) begin
			pulse_cnt <= pulse_cnt + count_t'(1);
		end
	end

	// publish at frame end, 0 for an unfiltered frame
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pulse_num_q <= '0;
		end else if (fval_fall) begin
			pulse_num_q <= en_q ? pulse_cnt : '0;
		end
	end

	assign o_fval      = fval_q;
	assign o_lval      = lval_q;
	assign o_pix       = pix_q;
	assign o_pulse_num = pulse_num_q;

endmodule

// ==== src/pulse_filter_1d.sv ====
module pulse_filter_1d (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_fval,
	input  logic                     i_lval,
	input  pulse_filter_pkg::pix_t   i_pix,
	input  logic                     i_filter_en,
	input  pulse_filter_pkg::width_t i_line_width,
	output logic                     o_fval,
	output logic                     o_lval,
	output pulse_filter_pkg::pix_t   o_pix,
	output pulse_filter_pkg::count_t o_pulse_num
);
	import pulse_filter_pkg::*;

	// both arrive 7 clocks after the pixel was taken
	det_result_t det;
	video_ctrl_t ctrl;

	// window and m/n/th pipeline
	impulse_detect u_detect (
		.clk     (clk),
		.i_rst_n (i_rst_n),
		.i_pix   (i_pix),
		.o_det   (det)
	);

	// column, edge flag and frame enable
	line_position u_position (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_fval       (i_fval),
		.i_lval       (i_lval),
		.i_filter_en  (i_filter_en),
		.i_line_width (i_line_width),
		.o_ctrl       (ctrl)
	);

	// last clock of the 8
	pixel_select u_select (
		.clk         (clk),
		.i_rst_n     (i_rst_n),
		.i_det       (det),
		.i_ctrl      (ctrl),
		.o_fval      (o_fval),
		.o_lval      (o_lval),
		.o_pix       (o_pix),
		.o_pulse_num (o_pulse_num)
	);

endmodule

// ==== test/pulse_filter_assert.sv ====
module pulse_filter_assert (
	input  logic                     clk,
	input  logic                     i_rst_n,
	input  logic                     i_fval,
	input  logic                     o_fval,
	input  logic                     o_lval,
	input  pulse_filter_pkg::count_t o_pulse_num
);
	import pulse_filter_pkg::*;

	// a line only exists inside a frame
	lval_in_frame: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_lval |-> o_fval)
		else $error("o_lval high while o_fval is low");

	// frame valid goes through the fixed pipeline delay
	fval_delay: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_fval == $past(i_fval, PIPE_LAT))
		else $error("o_fval does not follow i_fval by the pipeline delay");

	// published count only moves between frames
	count_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
		o_fval |-> $stable(o_pulse_num))
		else $error("o_pulse_num changed inside a frame");

endmodule

bind pulse_filter_1d pulse_filter_assert u_assert (
	.clk         (clk),
	.i_rst_n     (i_rst_n),
	.i_fval      (i_fval),
	.o_fval      (o_fval),
	.o_lval      (o_lval),
	.o_pulse_num (o_pulse_num)
);

// ==== include/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ----------------------------------------------------------------------
// stimulus source
// ----------------------------------------------------------------------

// galois lfsr, 16 bit, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic [15:0] n;
	n = s >> 1;
	if (s[0]) begin
		n = n ^ 16'hB400;
	end
	return n;
endfunction

// n random bits, one lfsr step per bit
task automatic lfsr_take(ref logic [15:0] state, input int n, output int unsigned val);
	val = 0;
	for (int i = 0; i < n; i++) begin
		state = lfsr_next(state);
		val = {val[30:0], state[0]};
	end
endtask

// ----------------------------------------------------------------------
// reference model
// ----------------------------------------------------------------------

// th = max(p1 + |p1 - p0|, p3 + |p3 - p4|)
function automatic int model_th(input int p0, input int p1, input int p3, input int p4);
	int m;
	int n;
	m = p1 + ((p1 >= p0) ? p1 - p0 : p0 - p1);
	n = p3 + ((p3 >= p4) ? p3 - p4 : p4 - p3);
	return (m >= n) ? m : n;
endfunction

// expected output of one line, pulses added to the frame count
task automatic model_line(input logic [7:0] line_in[$], input bit en,
		ref logic [7:0] exp_q[$], ref int unsigned pulses);
	int w;
	int th;
	logic [7:0] px;
	w = line_in.size();
	for (int c = 0; c < w; c++) begin
		px = line_in[c];
		// interior columns of enabled frames only
		if (en && c >= pulse_filter_pkg::EDGE_PIX && c < w - pulse_filter_pkg::EDGE_PIX) begin
			th = model_th(line_in[c-4], line_in[c-2], line_in[c+2], line_in[c+4]);
			if (int'(px) > th + pulse_filter_pkg::PULSE_THRESHOLD) begin
				px = th[7:0];
				pulses++;
			end
		end
		exp_q.push_back(px);
	end
endtask

// published count, 0 when the frame ran unfiltered
function automatic int unsigned model_count(input bit en, input int unsigned pulses);
	return en ? pulses : 0;
endfunction

`endif

// ==== test/tb_pulse_filter.sv ====
module tb_pulse_filter;
	import pulse_filter_pkg::*;

	`include "tb_model.svh"

	logic clk = 1'b0;
	logic rst_n;
	logic fval_in;
	logic lval_in;
	pix_t pix_in;
	logic filter_en;
	width_t line_width;
	logic fval_out;
	logic lval_out;
	pix_t pix_out;
	count_t pulse_num;

	// stimulus state and expected data
	logic [15:0] lfsr_st = 16'd52;
	logic [7:0] exp_q[$];
	int width_q[$];
	logic [8:0] fval_hist = '0;
	logic [8:0] lval_hist = '0;
	logic lval_prev = 1'b0;
	logic [7:0] exp_px;
	int out_cnt = 0;
	int line_w;
	int errors = 0;
	int lat_errs = 0;
	int n_tests = 0;
	int n_bad = 0;
	bit hung = 1'b0;

	pulse_filter_1d uut (
		.clk          (clk),
		.i_rst_n      (rst_n),
		.i_fval       (fval_in),
		.i_lval       (lval_in),
		.i_pix        (pix_in),
		.i_filter_en  (filter_en),
		.i_line_width (line_width),
		.o_fval       (fval_out),
		.o_lval       (lval_out),
		.o_pix        (pix_out),
		.o_pulse_num  (pulse_num)
	);

	always #50 clk = ~clk;

	task automatic report_fail(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic check_idle();
		if (fval_out !== 1'b0 || lval_out !== 1'b0 || pix_out !== '0 || pulse_num !== '0) begin
			report_fail("outputs not idle");
		end
	endtask

	task automatic finish_test(input string name, input int err0);
		n_tests++;
		if (errors == err0) begin
			$display("test %s: ok", name);
		end else begin
			n_bad++;
			$display("test %s: %0d errors", name, errors - err0);
		end
	endtask

	// ----------------------------------------------------------------------
	// output monitor, samples at the falling edge
	// ----------------------------------------------------------------------

	always @(negedge clk) begin
		// bit 8 holds the input from 8 clocks back
		fval_hist = {fval_hist[7:0], fval_in};
		lval_hist = {lval_hist[7:0], lval_in};
		if (fval_out !== fval_hist[8] || lval_out !== lval_hist[8]) begin
			report_fail("o_fval/o_lval not delayed by 8 cycles");
			lat_errs++;
		end
		if (lval_out === 1'b1) begin
			out_cnt++;
			if (exp_q.size() == 0) begin
				$display("output pixel at %0t arrived with no expected value", $time);
				errors++;
			end else begin
				exp_px = exp_q.pop_front();
				if (pix_out !== exp_px) begin
					report_fail($sformatf("pixel expected %0d got %0d", exp_px, pix_out));
				end
			end
		end
		// line closed, compare its length
		if (lval_out !== 1'b1 && lval_prev) begin
			if (width_q.size() == 0) begin
				$display("output line at %0t was never sent", $time);
				errors++;
			end else begin
				line_w = width_q.pop_front();
				if (out_cnt != line_w) begin
					report_fail($sformatf("line of %0d pixels, expected %0d", out_cnt, line_w));
					lat_errs++;
				end
			end
			out_cnt = 0;
		end
		lval_prev = (lval_out === 1'b1);
	end

	// ----------------------------------------------------------------------
	// one random frame, model first, then drive
	// ----------------------------------------------------------------------

	task automatic run_frame(input bit en, input bit flip);
		int unsigned v;
		int w;
		int lines;
		int wait_cnt;
		int unsigned pulses;
		logic [7:0] px;
		logic [7:0] line_q[$];
		if (hung) return;
		lfsr_take(lfsr_st, 5, v);
		w = 9 + int'(v);
		lfsr_take(lfsr_st, 2, v);
		lines = 3 + int'(v);
		pulses = 0;
		// enable taken in the gap before the frame
		@(posedge clk);
		filter_en <= en;
		line_width <= width_t'(w);
		lfsr_take(lfsr_st, 3, v);
		repeat (2 + int'(v)) @(posedge clk);
		fval_in <= 1'b1;
		for (int l = 0; l < lines; l++) begin
			line_q.delete();
			for (int c = 0; c < w; c++) begin
				lfsr_take(lfsr_st, 3, v);
				// roughly one in eight is a hot pixel
				if (v == 0) begin
					lfsr_take(lfsr_st, 4, v);
					px = 8'(230 + v);
				end else begin
					lfsr_take(lfsr_st, 8, v);
					px = v[7:0];
				end
				line_q.push_back(px);
			end
			model_line(line_q, en, exp_q, pulses);
			width_q.push_back(w);
			// mid frame toggle, must not reach this frame
			if (flip && l == lines / 2) begin
				filter_en <= ~en;
			end
			lfsr_take(lfsr_st, 2, v);
			repeat (1 + int'(v)) @(posedge clk);
			foreach (line_q[c]) begin
				lval_in <= 1'b1;
				pix_in <= line_q[c];
				@(posedge clk);
			end
			lval_in <= 1'b0;
		end
		lfsr_take(lfsr_st, 2, v);
		repeat (1 + int'(v)) @(posedge clk);
		fval_in <= 1'b0;
		// drain the pipeline
		wait_cnt = 0;
		do begin
			@(negedge clk);
			wait_cnt++;
		end while ((fval_out !== 1'b0 || exp_q.size() != 0) && wait_cnt < 200);
		if (fval_out !== 1'b0 || exp_q.size() != 0) begin
			$display("timeout at %0t waiting for the frame to leave the filter", $time);
			errors++;
			hung = 1'b1;
		end else if (pulse_num !== count_t'(model_count(en, pulses))) begin
			report_fail($sformatf("pulse count expected %0d got %0d",
				model_count(en, pulses), pulse_num));
		end
	endtask

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------

	initial begin
		int err0;
		rst_n = 1'b0;
		fval_in = 1'b0;
		lval_in = 1'b0;
		pix_in = '0;
		filter_en = 1'b0;
		line_width = width_t'(9);
		err0 = errors;
		repeat (10) begin
			@(posedge clk);
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		rst_n <= 1'b1;
		repeat (12) begin
			@(negedge clk);
			check_idle();
		end
		finish_test("reset", err0);

		err0 = errors;
		repeat (2) run_frame(1'b0, 1'b0);
		finish_test("filter off", err0);

		err0 = errors;
		repeat (5) run_frame(1'b1, 1'b0);
		finish_test("filter on", err0);

		// new enable only from the next frame
		err0 = errors;
		run_frame(1'b1, 1'b1);
		run_frame(1'b0, 1'b0);
		run_frame(1'b0, 1'b1);
		run_frame(1'b1, 1'b0);
		finish_test("enable change", err0);

		n_tests++;
		if (lat_errs == 0 && !hung) begin
			$display("test latency: ok");
		end else begin
			n_bad++;
			$display("test latency: %0d errors", lat_errs);
		end

		$display("tests %0d, failed %0d, errors %0d", n_tests, n_bad, errors);
		if (errors == 0 && !hung) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+include
src/pulse_filter_pkg.sv
src/impulse_detect.sv
src/line_position.sv
src/pixel_select.sv
src/pulse_filter_1d.sv
test/pulse_filter_assert.sv
test/tb_pulse_filter.sv

// ==== run_sim.sh ====
#!/bin/bash
# build with Verilator, then run and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pulse_filter -f sim.f \
	|| { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_pulse_filter)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && exit 0 || exit 1
